/* all.f */
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_tx_frame.sv
hw/uart_cmd_tx.sv
hw/uart_rx_frame.sv
hw/uart.sv
tests/uart_asserts.sv
tests/tb_uart.sv

/* Bender.yml */
package:
  name: uart_bridge

sources:
  - files:
      - hw/uart_pkg.sv
      - hw/uart_baud_gen.sv
      - hw/uart_tx_frame.sv
      - hw/uart_cmd_tx.sv
      - hw/uart_rx_frame.sv
      - hw/uart.sv
  - target: test
    files:
      - tests/uart_asserts.sv
      - tests/tb_uart.sv

/* tests/tb_uart.sv */
`default_nettype none

module tb_uart
  import uart_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // 18 + 2 + 8 + 3 + 2 frames over all tests plus 20 percent
  localparam int frames_used    = 33;
  localparam int timeout_cycles = frames_used * frame_bits * bit_div * 6 / 5;

  logic     clk;
  logic     rst_n;
  cmd_t     cmd_in;
  logic     cmd_vld;
  logic     cmd_rdy;
  logic     tx;
  logic     rx_drv;
  logic     loop_en;
  logic     rx_line;
  rx_word_t read_data;
  logic     read_rdy;

  int          cycle = 0;
  int          errors = 0;
  logic [15:0] lfsr = 16'd9305;
  rx_word_t    rx_q[$];
  int          rx_t[$];

  assign rx_line = loop_en ? tx : rx_drv;

  uart UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx_line),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // every read_rdy pulse with the cycle it was seen in
  always @(negedge clk) begin
    if (read_rdy === 1'b1) begin
      rx_q.push_back(read_data);
      rx_t.push_back(cycle);
    end
  end

  initial begin
    wait (cycle >= timeout_cycles);
    $display("timeout: no result after %0d clock cycles", timeout_cycles);
    $display("Regression failed");
    $fatal(1);
  end

  // bound protocol checks count their own failures
  always @(posedge clk) begin
    if (UUT.u_asserts.fail_count != 0) begin
      abort_run("a protocol assertion on the DUT failed");
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    int         i;
    b = '0;
    for (i = 0; i < 8; i++) begin
      b    = {b[6:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return b;
  endfunction

  // 1 when the byte holds an even number of ones
  function automatic logic parity_of(input logic [7:0] b);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < 8; i++) ones += b[i];
    return (ones % 2 == 0);
  endfunction

  function automatic rx_word_t word_of(input logic perr, input logic [7:0] d);
    rx_word_t w;
    w.parity_err = perr;
    w.data       = d;
    return w;
  endfunction

  task automatic value_error(input string msg);
    errors++;
    $display("Error at %0d ns: %s", $time, msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_cmd(input cmd_t got, input cmd_t exp, input string what);
    if (got !== exp) value_error($sformatf("%s got %04h expected %04h", what, got, exp));
  endtask

  task automatic check_word(input rx_word_t got, input rx_word_t exp, input string what);
    if (got !== exp) value_error($sformatf("%s got %03h expected %03h", what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) value_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic check_cycles(input int got, input int exp, input int tol, input string what);
    if (got < exp - tol || got > exp + tol) begin
      value_error($sformatf("%s took %0d cycles, expected %0d +- %0d", what, got, exp, tol));
    end
  endtask

  // decodes one frame from tx at mid-bit points
  task automatic recv_tx_frame(output logic [7:0] data, output logic par, output logic stop);
    int i;
    do @(negedge clk); while (tx !== 1'b0);
    repeat (half_div) @(negedge clk);
    check_bit(tx, 1'b0, "tx start bit");
    for (i = 0; i < 8; i++) begin
      repeat (bit_div) @(negedge clk);
      data[i] = tx;
    end
    repeat (bit_div) @(negedge clk);
    par = tx;
    repeat (bit_div) @(negedge clk);
    stop = tx;
  endtask

  task automatic drive_rx_frame(input logic [7:0] b, input bit bad_par, input bit bad_stop,
                                output int t_start);
    logic [frame_bits-1:0] bits;
    int                    i;
    bits = {~bad_stop, parity_of(b) ^ bad_par, b, 1'b0};
    @(posedge clk);
    t_start = cycle + 1;
    for (i = 0; i < frame_bits; i++) begin
      rx_drv <= bits[i];
      repeat (bit_div) @(posedge clk);
    end
    rx_drv <= 1'b1;
    repeat (bit_div) @(posedge clk);
  endtask

  task automatic expect_rx(input rx_word_t exp, input int t_start);
    if (rx_q.size() != 1) begin
      abort_run($sformatf("expected one read_rdy pulse per frame, saw %0d", rx_q.size()));
    end
    check_word(rx_q.pop_front(), exp, "read_data");
    check_cycles(rx_t.pop_front() - t_start, 10 * bit_div + half_div, 2, "rx latency");
  endtask

  task automatic send_cmd(input cmd_t c, input bit extra_vld);
    logic [7:0] d_hi;
    logic [7:0] d_lo;
    logic       p_hi;
    logic       p_lo;
    logic       s_hi;
    logic       s_lo;
    int         t_acc;
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    @(posedge clk);
    t_acc = cycle + 1;
    cmd_vld <= 1'b0;
    @(negedge clk);
    check_bit(cmd_rdy, 1'b0, "cmd_rdy after acceptance");
    recv_tx_frame(d_hi, p_hi, s_hi);
    if (extra_vld) begin
      // ignored while busy so the low byte still comes from c
      @(posedge clk);
      cmd_in  <= ~c;
      cmd_vld <= 1'b1;
      @(posedge clk);
      cmd_vld <= 1'b0;
      @(negedge clk);
      check_bit(cmd_rdy, 1'b0, "cmd_rdy between frames");
    end
    recv_tx_frame(d_lo, p_lo, s_lo);
    while (cmd_rdy !== 1'b1) @(negedge clk);
    check_cycles(cycle - t_acc, 2 * frame_bits * bit_div + 2, 4, "command");
    check_cmd({d_hi, d_lo}, c, "tx bytes");
    check_bit(p_hi, parity_of(c.hi), "high byte parity");
    check_bit(p_lo, parity_of(c.lo), "low byte parity");
    check_bit(s_hi, 1'b1, "high byte stop");
    check_bit(s_lo, 1'b1, "low byte stop");
  endtask

  task automatic test_reset();
    int i;
    @(negedge clk);
    check_bit(tx, 1'b1, "tx after reset");
    check_bit(cmd_rdy, 1'b1, "cmd_rdy after reset");
    check_bit(read_rdy, 1'b0, "read_rdy after reset");
    check_word(read_data, word_of(1'b0, 8'h00), "read_data after reset");
    for (i = 0; i < 100; i++) begin
      @(negedge clk);
      check_bit(tx, 1'b1, "tx idle");
    end
  endtask

  task automatic test_transmit();
    cmd_t c;
    int   n;
    send_cmd(16'ha55a, 1'b0);
    for (n = 0; n < 8; n++) begin
      c.hi = rand_byte();
      c.lo = rand_byte();
      send_cmd(c, 1'b0);
    end
  endtask

  task automatic test_cmd_timing();
    int i;
    send_cmd(16'h3cc3, 1'b1);
    for (i = 0; i < 2 * bit_div; i++) begin
      @(negedge clk);
      check_bit(tx, 1'b1, "tx after command");
      check_bit(cmd_rdy, 1'b1, "cmd_rdy after command");
    end
  endtask

  task automatic test_receive();
    logic [7:0] b;
    int         t;
    int         n;
    for (n = 0; n < 8; n++) begin
      b = rand_byte();
      drive_rx_frame(b, 1'b0, 1'b0, t);
      expect_rx(word_of(1'b0, b), t);
    end
  endtask

  task automatic test_rx_errors();
    int t;
    drive_rx_frame(8'h96, 1'b1, 1'b0, t);
    expect_rx(word_of(parity_check, 8'h96), t);
    drive_rx_frame(8'h5e, 1'b0, 1'b1, t);
    if (rx_q.size() != 0) abort_run("read_rdy pulsed for a frame with a low stop bit");
    drive_rx_frame(8'hc1, 1'b0, 1'b0, t);
    expect_rx(word_of(1'b0, 8'hc1), t);
  endtask

  task automatic test_loopback();
    @(posedge clk);
    loop_en <= 1'b1;
    send_cmd(16'h81e7, 1'b0);
    if (rx_q.size() != 2) abort_run("loopback did not return two received bytes");
    check_word(rx_q.pop_front(), word_of(1'b0, 8'h81), "loopback high byte");
    check_word(rx_q.pop_front(), word_of(1'b0, 8'he7), "loopback low byte");
    rx_t.delete();
    @(posedge clk);
    loop_en <= 1'b0;
  endtask

  initial begin
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx_drv  = 1'b1;
    loop_en = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_transmit();
    test_cmd_timing();
    test_receive();
    test_rx_errors();
    test_loopback();
    if (errors == 0 && UUT.u_asserts.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/uart_asserts.sv */
`default_nettype none

module uart_asserts (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic busy,
  input logic tx,
  input logic read_rdy
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [1:0] falls_left;
  logic       busy_q;
  int         fail_count = 0;

  // busy falls still owed before the command may finish
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q     <= 1'b0;
      falls_left <= '0;
    end else begin
      busy_q <= busy;
      if (cmd_rdy && cmd_vld) begin
        falls_left <= 2'd2;
      end else if (busy_q && !busy && falls_left != 2'd0) begin
        falls_left <= falls_left - 1'b1;
      end
    end
  end

  idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_rdy && !busy) |-> tx)
    else begin
      fail_count++;
      $error("tx left the idle level with no frame in flight");
    end

  rdy_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else begin
      fail_count++;
      $error("read_rdy held for more than one cycle");
    end

  rdy_low_in_cmd: assert property (@(posedge clk) disable iff (!rst_n)
    (falls_left != 2'd0) |-> !cmd_rdy)
    else begin
      fail_count++;
      $error("cmd_rdy rose before both frames finished");
    end

endmodule

bind uart uart_asserts u_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .busy     (tx_busy),
  .tx       (tx),
  .read_rdy (read_rdy)
);

`default_nettype wire

/* hw/uart.sv */
`default_nettype none

module uart
  import uart_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  cmd_t     cmd_in,
  input  logic     cmd_vld,
  output logic     cmd_rdy,
  input  logic     rx,
  output logic     tx,
  output rx_word_t read_data,
  output logic     read_rdy
);

  logic [7:0] tx_byte;
  logic       tx_send;
  logic       tx_busy;

  // command sequencer feeding the frame shifter
  uart_cmd_tx u_cmd_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .byte_out (tx_byte),
    .send     (tx_send),
    .busy     (tx_busy)
  );

  uart_tx_frame u_tx_frame (
    .clk     (clk),
    .rst_n   (rst_n),
    .byte_in (tx_byte),
    .send    (tx_send),
    .busy    (tx_busy),
    .tx      (tx)
  );

  // receive path runs on its own
  uart_rx_frame u_rx_frame (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

endmodule

`default_nettype wire

/* hw/uart_rx_frame.sv */
`default_nettype none

module uart_rx_frame
  import uart_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rx,
  output rx_word_t read_data,
  output logic     read_rdy
);

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_data,
    st_parity,
    st_stop
  } state_t;

  state_t     state;
  logic       rx_meta;
  logic       rx_sync;
  logic       rx_last;
  logic       rx_fall;
  logic [2:0] bit_idx;
  logic [7:0] shreg;
  logic       par_q;
  logic       mid_tick;

  // two stage synchronizer and a delayed copy for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
    end
  end

  assign rx_fall = rx_last & ~rx_sync;

  uart_baud_gen u_baud (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (state != st_idle),
    .bit_tick (),
    .mid_tick (mid_tick)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      bit_idx   <= '0;
      read_rdy  <= 1'b0;
      read_data <= '0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        st_idle: if (rx_fall) state <= st_start;
        st_start: begin
          if (mid_tick) begin
            // glitch shorter than half a bit goes back to idle
            if (!rx_sync) begin
              state   <= st_data;
              bit_idx <= '0;
            end else begin
              state <= st_idle;
            end
          end
        end
        st_data: begin
          if (mid_tick) begin
            if (bit_idx == 3'(data_bits - 1)) begin
              state <= st_parity;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        st_parity: if (mid_tick) state <= st_stop;
        st_stop: begin
          if (mid_tick) begin
            state <= st_idle;
            // a low stop bit drops the frame
            if (rx_sync) begin
              read_rdy             <= 1'b1;
              read_data.data       <= shreg;
              read_data.parity_err <= parity_check && (par_q != odd_parity(shreg));
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // data arrives lsb first
  always_ff @(posedge clk) begin
    if (state == st_data && mid_tick) begin
      shreg <= {rx_sync, shreg[7:1]};
    end
    if (state == st_parity && mid_tick) begin
      par_q <= rx_sync;
    end
  end

endmodule

`default_nettype wire

/* hw/uart_cmd_tx.sv */
`default_nettype none

module uart_cmd_tx
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_t       cmd_in,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  output logic [7:0] byte_out,
  output logic       send,
  input  logic       busy
);

  typedef enum logic [1:0] {
    st_idle,
    st_high,
    st_low
  } state_t;

  state_t state;
  cmd_t   cmd_q;
  logic   send_hi_q;
  logic   busy_q;
  logic   busy_fall;

  assign busy_fall = busy_q & ~busy;
  assign cmd_rdy   = (state == st_idle);

  // low byte goes out in the cycle right after the high frame ends
  assign send     = send_hi_q | ((state == st_high) & busy_fall);
  assign byte_out = send_hi_q ? cmd_q.hi : cmd_q.lo;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      send_hi_q <= 1'b0;
      busy_q    <= 1'b0;
    end else begin
      send_hi_q <= 1'b0;
      busy_q    <= busy;
      case (state)
        st_idle: begin
          if (cmd_vld) begin
            state     <= st_high;
            send_hi_q <= 1'b1;
          end
        end
        st_high: if (busy_fall) state <= st_low;
        st_low:  if (busy_fall) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_rdy && cmd_vld) begin
      cmd_q <= cmd_in;
    end
  end

endmodule

`default_nettype wire

/* hw/uart_tx_frame.sv */
`default_nettype none

module uart_tx_frame
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] byte_in,
  input  logic       send,
  output logic       busy,
  output logic       tx
);

  logic [frame_bits-1:0] shreg;
  logic [bit_cnt_w-1:0]  bit_idx;
  logic                  bit_tick;
  logic                  last_bit;

  uart_baud_gen u_baud (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (busy),
    .bit_tick (bit_tick),
    .mid_tick ()
  );

  assign last_bit = (bit_idx == bit_cnt_w'(frame_bits - 1));

  // bit 0 of the shift register is the line
  assign tx = shreg[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shreg <= '1;
    end else if (send && !busy) begin
      // stop, parity, data, start from msb down
      shreg <= {1'b1, odd_parity(byte_in), byte_in, 1'b0};
    end else if (bit_tick) begin
      // ones fill in behind, so the line idles high
      shreg <= {1'b1, shreg[frame_bits-1:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      bit_idx <= '0;
    end else if (send && !busy) begin
      busy    <= 1'b1;
      bit_idx <= '0;
    end else if (bit_tick) begin
      if (last_bit) begin
        // stop bit period done
        busy <= 1'b0;
      end else begin
        bit_idx <= bit_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/uart_baud_gen.sv */
`default_nettype none

module uart_baud_gen
  import uart_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic bit_tick,
  output logic mid_tick
);

  logic [div_w-1:0] cnt;
  logic             at_end;
  logic             at_mid;

  assign at_end = (cnt == div_w'(bit_div - 1));
  assign at_mid = (cnt == div_w'(mid_cnt));

  // restarts from zero each time run rises
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!run) begin
      cnt <= '0;
    end else if (at_end) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign bit_tick = run & at_end;
  assign mid_tick = run & at_mid;

endmodule

`default_nettype wire

/* hw/uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // bit timing for a 50 MHz clock
  localparam int clk_hz   = 50_000_000;
  localparam int baud     = 115_200;
  localparam int bit_div  = clk_hz / baud;
  localparam int half_div = bit_div / 2;
  localparam int div_w    = $clog2(bit_div);

  // frame is start, 8 data LSB first, odd parity, stop
  localparam int data_bits  = 8;
  localparam int frame_bits = 11;
  localparam int bit_cnt_w  = $clog2(frame_bits);

  // 0 reports every received byte as parity clean
  localparam bit parity_check = 1'b1;

  // two sync stages plus edge detect between rx pin and counter start
  localparam int rx_sync_lat = 3;

  // mid tick pulled in by the rx input latency so sampling
  // lands on the true middle of each bit at the pin
  localparam int mid_cnt = half_div - 1 - rx_sync_lat;

  // host command with the high byte sent first
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } cmd_t;

  // received byte with its parity result
  typedef struct packed {
    logic       parity_err;
    logic [7:0] data;
  } rx_word_t;

  // parity bit that makes the count of ones odd
  function automatic logic odd_parity(input logic [7:0] d);
    return ~^d;
  endfunction

endpackage

`default_nettype wire
